/* project.f */
src/mips_pkg.sv
src/mips_alu.sv
src/exec_unit.sv
src/instr_decoder.sv
src/fetch_unit.sv
src/cp0_apb_regs.sv
src/mips_core_top.sv
verification/mips_checker.sv
verification/mips_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the core testbench with verilator, then judge the log
set -u
cd "$(dirname "$0")"

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -f project.f --top-module mips_tb -Mdir "$BUILD" -o mips_sim
if [ $? -ne 0 ]; then
   echo "verilator compile step failed"
   exit 1
fi

# keep running past assertion errors so the testbench prints its summary
"$BUILD/mips_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0

/* src/cp0_apb_regs.sv */
`timescale 1ns/1ns

module cp0_apb_regs (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::apb_req_t apb,
   input  mips_pkg::ctrl_t    ctrl,
   input  mips_pkg::word_t    pc,
   output mips_pkg::apb_rsp_t apb_rsp,
   output logic               advance,
   output logic               halted
);

   logic               run;
   mips_pkg::cause_e   cause;
   mips_pkg::word_t    epc;
   mips_pkg::cp0_addr_e addr;
   logic               access;
   logic               mapped;
   logic               halting;

   assign addr   = mips_pkg::cp0_addr_e'(apb.paddr);
   // access phase, no wait states
   assign access = apb.psel & apb.penable;
   assign mapped = (addr == mips_pkg::CP0_CTRL) || (addr == mips_pkg::CP0_STATUS) ||
                   (addr == mips_pkg::CP0_EPC);

   assign advance = run & ~halted;
   // a syscall or reserved instruction retiring now
   assign halting = advance & (ctrl.syscall | ctrl.reserved);

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         run    <= 1'b0;
         halted <= 1'b0;
         cause  <= mips_pkg::CAUSE_NONE;
      end else begin
         // only ctrl is writable
         if (access && apb.pwrite && addr == mips_pkg::CP0_CTRL) begin
            run <= apb.pwdata[0];
         end
         // sticky until reset
         if (halting) begin
            halted <= 1'b1;
            cause  <= ctrl.syscall ? mips_pkg::CAUSE_SYSCALL : mips_pkg::CAUSE_RI;
         end
      end
   end

   // address of the halting instruction itself
   always_ff @(posedge clk) begin
      if (halting) begin
         epc <= pc;
      end
   end

   // read mux, unmapped offsets give zero
   always_comb begin
      case (addr)
         mips_pkg::CP0_CTRL:   apb_rsp.prdata = {31'h0, run};
         mips_pkg::CP0_STATUS: apb_rsp.prdata = {25'h0, cause, 1'b0, halted};
         mips_pkg::CP0_EPC:    apb_rsp.prdata = epc;
         default:              apb_rsp.prdata = '0;
      endcase
      // a write to a read-only register answers with zero
      if (apb.pwrite && addr != mips_pkg::CP0_CTRL) begin
         apb_rsp.prdata = '0;
      end
   end

   assign apb_rsp.pready = 1'b1;
   // status and epc are read only
   assign apb_rsp.pslverr = access & (~mapped | (apb.pwrite & addr != mips_pkg::CP0_CTRL));

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
   input  logic                   clk,
   input  logic                   rst_b,
   input  logic                   advance,
   input  mips_pkg::word_t        pc,
   input  mips_pkg::inst_fields_t fields,
   input  mips_pkg::ctrl_t        ctrl,
   input  mips_pkg::word_t        dmem_rdata,
   output mips_pkg::word_t        rs_data,
   output logic                   eq,
   output mips_pkg::dmem_req_t    dmem
);

   mips_pkg::word_t   regs [32];
   mips_pkg::word_t   rt_data;
   mips_pkg::word_t   imm_ext;
   mips_pkg::word_t   op_b;
   mips_pkg::word_t   alu_y;
   mips_pkg::word_t   wb_data;
   mips_pkg::reg_idx_t dest;

   // combinational read ports, $zero is hardwired
   assign rs_data = (fields.rs == '0) ? '0 : regs[fields.rs];
   assign rt_data = (fields.rt == '0) ? '0 : regs[fields.rt];

   // branch compare feeds the fetch unit
   assign eq = (rs_data == rt_data);

   assign imm_ext = ctrl.sign_ext ? {{16{fields.imm16[15]}}, fields.imm16}
                                  : {16'h0, fields.imm16};
   assign op_b = ctrl.alu_src_imm ? imm_ext : rt_data;

   mips_alu mips_alu_i (
      .op    (ctrl.alu_op),
      .a     (rs_data),
      .b     (op_b),
      .shamt (fields.shamt),
      .y     (alu_y)
   );

   // jal writes $ra, r-type writes rd, the rest rt
   always_comb begin
      if (ctrl.link) begin
         dest = 5'd31;
      end else if (ctrl.reg_dst_rd) begin
         dest = fields.rd;
      end else begin
         dest = fields.rt;
      end
   end

   // no delay slot, so the link is the next sequential address
   always_comb begin
      if (ctrl.link) begin
         wb_data = pc + 32'd4;
      end else if (ctrl.mem_to_reg) begin
         wb_data = dmem_rdata;
      end else begin
         wb_data = alu_y;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (advance && ctrl.reg_write && dest != '0) begin
         regs[dest] <= wb_data;
      end
   end

   // word access only, low address bits dropped
   assign dmem.addr  = alu_y[31:2];
   assign dmem.wdata = rt_data;
   assign dmem.we    = advance & ctrl.mem_write;

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit #(
   parameter mips_pkg::word_t text_start = mips_pkg::TEXT_START_DEFAULT
) (
   input  logic                   clk,
   input  logic                   rst_b,
   input  logic                   advance,
   input  mips_pkg::ctrl_t        ctrl,
   input  mips_pkg::inst_fields_t fields,
   input  mips_pkg::word_t        rs_data,
   input  logic                   eq,
   output mips_pkg::word_t        pc,
   output logic [29:0]            inst_addr
);

   mips_pkg::word_t pc_plus4;
   mips_pkg::word_t br_target;
   mips_pkg::word_t pc_next;
   logic            br_taken;
   logic            halting;

   assign pc_plus4 = pc + 32'd4;
   // offset is a word count relative to the following instruction
   assign br_target = pc_plus4 + {{14{fields.imm16[15]}}, fields.imm16, 2'b00};
   // beq wants eq, bne wants not eq
   assign br_taken = eq ^ ctrl.branch_ne;
   assign halting = ctrl.syscall | ctrl.reserved;

   always_comb begin
      case (ctrl.pc_sel)
         mips_pkg::PC_BRANCH: pc_next = br_taken ? br_target : pc_plus4;
         mips_pkg::PC_JUMP:   pc_next = {pc[31:28], fields.target26, 2'b00};
         mips_pkg::PC_REG:    pc_next = rs_data;
         default:             pc_next = pc_plus4;
      endcase
   end

   // pc freezes on the halting instruction so epc and the pc agree
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= text_start;
      end else if (advance && !halting) begin
         pc <= pc_next;
      end
   end

   // memories are word addressed
   assign inst_addr = pc[31:2];

endmodule

/* src/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
   input  mips_pkg::word_t        inst,
   output mips_pkg::inst_fields_t fields,
   output mips_pkg::ctrl_t        ctrl
);

   mips_pkg::opcode_e opcode;
   mips_pkg::funct_e  funct;

   assign opcode = mips_pkg::opcode_e'(inst[31:26]);
   assign funct  = mips_pkg::funct_e'(inst[5:0]);

   // plain field split, no extension here
   assign fields.rs       = inst[25:21];
   assign fields.rt       = inst[20:16];
   assign fields.rd       = inst[15:11];
   assign fields.shamt    = inst[10:6];
   assign fields.imm16    = inst[15:0];
   assign fields.target26 = inst[25:0];

   always_comb begin
      // default is a no-op with sequential flow
      ctrl = '0;
      ctrl.alu_op = mips_pkg::ALU_ADD;
      ctrl.pc_sel = mips_pkg::PC_SEQ;
      case (opcode)
         mips_pkg::OP_SPECIAL: begin
            ctrl.reg_dst_rd = 1'b1;
            ctrl.reg_write  = 1'b1;
            case (funct)
               mips_pkg::FN_ADD, mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUB, mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND: ctrl.alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:  ctrl.alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR: ctrl.alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR: ctrl.alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT: ctrl.alu_op = mips_pkg::ALU_SLT;
               // shifts take rt and shamt
               mips_pkg::FN_SLL: ctrl.alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL: ctrl.alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA: ctrl.alu_op = mips_pkg::ALU_SRA;
               mips_pkg::FN_JR: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.pc_sel    = mips_pkg::PC_REG;
               end
               mips_pkg::FN_SYSCALL: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.syscall   = 1'b1;
               end
               default: begin
                  ctrl.reg_write = 1'b0;
                  ctrl.reserved  = 1'b1;
               end
            endcase
         end
         mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         mips_pkg::OP_SLTI: begin
            ctrl.alu_op      = mips_pkg::ALU_SLT;
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         // logical immediates are zero extended
         mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            case (opcode)
               mips_pkg::OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
               mips_pkg::OP_ORI:  ctrl.alu_op = mips_pkg::ALU_OR;
               mips_pkg::OP_XORI: ctrl.alu_op = mips_pkg::ALU_XOR;
               default:           ctrl.alu_op = mips_pkg::ALU_LUI;
            endcase
         end
         // address is rs plus signed offset
         mips_pkg::OP_LW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            ctrl.mem_to_reg  = 1'b1;
            ctrl.reg_write   = 1'b1;
         end
         mips_pkg::OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.sign_ext    = 1'b1;
            ctrl.mem_write   = 1'b1;
         end
         mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
            ctrl.pc_sel    = mips_pkg::PC_BRANCH;
            ctrl.branch_ne = (opcode == mips_pkg::OP_BNE);
         end
         mips_pkg::OP_J: ctrl.pc_sel = mips_pkg::PC_JUMP;
         mips_pkg::OP_JAL: begin
            ctrl.pc_sel    = mips_pkg::PC_JUMP;
            ctrl.link      = 1'b1;
            ctrl.reg_write = 1'b1;
         end
         default: ctrl.reserved = 1'b1;
      endcase
   end

endmodule

/* src/mips_alu.sv */
`timescale 1ns/1ns

module mips_alu (
   input  mips_pkg::alu_op_e op,
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  logic [4:0]        shamt,
   output mips_pkg::word_t   y
);

   always_comb begin
      case (op)
         // add and sub wrap, no overflow trap
         mips_pkg::ALU_ADD: begin
            y = a + b;
         end
         mips_pkg::ALU_SUB: begin
            y = a - b;
         end
         mips_pkg::ALU_AND: begin
            y = a & b;
         end
         mips_pkg::ALU_OR: begin
            y = a | b;
         end
         mips_pkg::ALU_XOR: begin
            y = a ^ b;
         end
         mips_pkg::ALU_NOR: begin
            y = ~(a | b);
         end
         // signed compare for slt and slti
         mips_pkg::ALU_SLT: begin
            y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         end
         // shifts act on rt, which arrives on b
         mips_pkg::ALU_SLL: begin
            y = b << shamt;
         end
         mips_pkg::ALU_SRL: begin
            y = b >> shamt;
         end
         mips_pkg::ALU_SRA: begin
            y = $unsigned($signed(b) >>> shamt);
         end
         // immediate into the upper half
         mips_pkg::ALU_LUI: begin
            y = {b[15:0], 16'h0};
         end
         default: begin
            y = '0;
         end
      endcase
   end

endmodule

/* src/mips_core_top.sv */
`timescale 1ns/1ns

module mips_core_top #(
   parameter mips_pkg::word_t text_start = mips_pkg::TEXT_START_DEFAULT
) (
   input  logic                clk,
   input  logic                rst_b,
   input  mips_pkg::word_t     inst,
   input  mips_pkg::word_t     dmem_rdata,
   input  mips_pkg::apb_req_t  apb,
   output logic [29:0]         inst_addr,
   output mips_pkg::dmem_req_t dmem,
   output mips_pkg::apb_rsp_t  apb_rsp,
   output logic                halted
);

   mips_pkg::inst_fields_t fields;
   mips_pkg::ctrl_t        ctrl;
   mips_pkg::word_t        pc;
   mips_pkg::word_t        rs_data;
   logic                   eq;
   // one instruction retires per edge while high
   logic                   advance;

   fetch_unit #(.text_start(text_start)) fetch_unit_i (
      .clk       (clk),
      .rst_b     (rst_b),
      .advance   (advance),
      .ctrl      (ctrl),
      .fields    (fields),
      .rs_data   (rs_data),
      .eq        (eq),
      .pc        (pc),
      .inst_addr (inst_addr)
   );

   instr_decoder instr_decoder_i (
      .inst   (inst),
      .fields (fields),
      .ctrl   (ctrl)
   );

   exec_unit exec_unit_i (
      .clk        (clk),
      .rst_b      (rst_b),
      .advance    (advance),
      .pc         (pc),
      .fields     (fields),
      .ctrl       (ctrl),
      .dmem_rdata (dmem_rdata),
      .rs_data    (rs_data),
      .eq         (eq),
      .dmem       (dmem)
   );

   cp0_apb_regs cp0_apb_regs_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .apb     (apb),
      .ctrl    (ctrl),
      .pc      (pc),
      .apb_rsp (apb_rsp),
      .advance (advance),
      .halted  (halted)
   );

endmodule

/* src/mips_pkg.sv */
package mips_pkg;

   // basic widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   // reset value of the pc, overridden through the top parameter
   localparam word_t TEXT_START_DEFAULT = 32'h0040_0000;

   // primary opcodes, syscall and jr live under special
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDI    = 6'h08,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_e;

   // r-type function codes
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_JR      = 6'h08,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_e;

   // next pc source
   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pc_sel_e;

   // exception codes as they appear in status bits 6:2
   typedef enum logic [4:0] {
      CAUSE_NONE    = 5'd0,
      CAUSE_SYSCALL = 5'd8,
      CAUSE_RI      = 5'd10
   } cause_e;

   // apb register offsets
   typedef enum logic [3:0] {
      CP0_CTRL   = 4'h0,
      CP0_STATUS = 4'h4,
      CP0_EPC    = 4'h8
   } cp0_addr_e;

   typedef struct packed {
      reg_idx_t    rs;
      reg_idx_t    rt;
      reg_idx_t    rd;
      logic [4:0]  shamt;
      logic [15:0] imm16;
      logic [25:0] target26;
   } inst_fields_t;

   typedef struct packed {
      alu_op_e alu_op;
      logic    reg_dst_rd;
      logic    alu_src_imm;
      logic    sign_ext;
      logic    mem_to_reg;
      logic    mem_write;
      logic    reg_write;
      logic    link;
      pc_sel_e pc_sel;
      logic    branch_ne;
      logic    syscall;
      logic    reserved;
   } ctrl_t;

   typedef struct packed {
      logic [29:0] addr;
      word_t       wdata;
      logic        we;
   } dmem_req_t;

   typedef struct packed {
      logic       psel;
      logic       penable;
      logic       pwrite;
      logic [3:0] paddr;
      word_t      pwdata;
   } apb_req_t;

   typedef struct packed {
      word_t prdata;
      logic  pready;
      logic  pslverr;
   } apb_rsp_t;

endpackage

/* verification/mips_checker.sv */
`timescale 1ns/1ns

module mips_checker (
   input logic                clk,
   input logic                rst_b,
   input mips_pkg::apb_req_t  apb,
   input mips_pkg::apb_rsp_t  apb_rsp,
   input mips_pkg::dmem_req_t dmem,
   input logic [29:0]         inst_addr,
   input logic                halted
);

   // failures so far, read by the testbench summary
   int fail_count = 0;

   // no wait states, every access phase completes at once
   pready_in_access: assert property (@(posedge clk) disable iff (!rst_b)
      (apb.psel && apb.penable) |-> apb_rsp.pready)
      else begin
         $error("pready low during an apb access phase");
         fail_count++;
      end

   // no data write while halted or in reset
   no_write_when_stopped: assert property (@(posedge clk)
      !(dmem.we && (halted || !rst_b)))
      else begin
         $error("data memory write while halted or in reset");
         fail_count++;
      end

   // pc parked on the halting instruction
   pc_frozen_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else begin
         $error("instruction address moved while halted");
         fail_count++;
      end

   // halt is sticky until reset
   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> halted)
      else begin
         $error("halted dropped without a reset");
         fail_count++;
      end

endmodule

/* verification/mips_tb.sv */
`timescale 1ns/1ns

module mips_tb;

   localparam mips_pkg::word_t TEXT = 32'h0040_0000;
   // data slot that lw reads
   localparam int LOAD_SLOT = 200;

   logic                clk;
   logic                rst_b;
   mips_pkg::word_t     inst;
   mips_pkg::word_t     dmem_rdata;
   mips_pkg::apb_req_t  apb;
   logic [29:0]         inst_addr;
   mips_pkg::dmem_req_t dmem;
   mips_pkg::apb_rsp_t  apb_rsp;
   logic                halted;

   // text sits on a 4 KiB boundary so the low address bits index the program
   mips_pkg::word_t imem [1024];
   mips_pkg::word_t dmem_mem [256];
   mips_pkg::word_t load_word;
   // slots and the words each must hold after a run
   int              exp_slot [$];
   mips_pkg::word_t exp_val [$];
   int              prog_len;
   int              checks;
   int              value_errors;

   mips_pkg::funct_e r_ops [12] = '{mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB,
      mips_pkg::FN_SUBU, mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
      mips_pkg::FN_SLT, mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA};
   mips_pkg::opcode_e i_ops [7] = '{mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI,
      mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI};

   mips_core_top #(.text_start(TEXT)) mips_core_top_i (.*);

   bind mips_core_top mips_checker mips_checker_i (.clk(clk), .rst_b(rst_b), .apb(apb),
      .apb_rsp(apb_rsp), .dmem(dmem), .inst_addr(inst_addr), .halted(halted));

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // both memories answer in the same cycle
   assign inst       = imem[inst_addr[9:0]];
   assign dmem_rdata = dmem_mem[dmem.addr[7:0]];

   // refilled on every reset cycle, written at the edge otherwise
   always @(posedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < 256; i++) begin
            dmem_mem[i] <= (i == LOAD_SLOT) ? load_word : fill_word(i);
         end
      end else if (dmem.we) begin
         dmem_mem[dmem.addr[7:0]] <= dmem.wdata;
      end
   end

   function automatic mips_pkg::word_t fill_word(int i);
      return {16'hc0de, ~8'(i), 8'(i)};
   endfunction

   function automatic mips_pkg::word_t enc_r(mips_pkg::funct_e fn, logic [4:0] rs,
                                             logic [4:0] rt, logic [4:0] rd, logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic mips_pkg::word_t enc_i(mips_pkg::opcode_e op, logic [4:0] rs,
                                             logic [4:0] rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // absolute jump to a program index
   function automatic mips_pkg::word_t enc_j(mips_pkg::opcode_e op, int idx);
      mips_pkg::word_t target;
      target = TEXT + 32'(idx * 4);
      return {op, target[27:2]};
   endfunction

   // r-type results, add and sub wrap, slt signed
   function automatic mips_pkg::word_t r_result(mips_pkg::funct_e fn, mips_pkg::word_t a,
                                                mips_pkg::word_t b, logic [4:0] sh);
      case (fn)
         mips_pkg::FN_ADD, mips_pkg::FN_ADDU: return a + b;
         mips_pkg::FN_SUB, mips_pkg::FN_SUBU: return a - b;
         mips_pkg::FN_AND: return a & b;
         mips_pkg::FN_OR:  return a | b;
         mips_pkg::FN_XOR: return a ^ b;
         mips_pkg::FN_NOR: return ~(a | b);
         mips_pkg::FN_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         mips_pkg::FN_SLL: return b << sh;
         mips_pkg::FN_SRL: return b >> sh;
         mips_pkg::FN_SRA: return $unsigned($signed(b) >>> sh);
         default:          return 32'h0;
      endcase
   endfunction

   // arithmetic immediates sign extend, logical ones zero extend
   function automatic mips_pkg::word_t i_result(mips_pkg::opcode_e op, mips_pkg::word_t a,
                                                logic [15:0] imm);
      mips_pkg::word_t sx;
      sx = {{16{imm[15]}}, imm};
      case (op)
         mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: return a + sx;
         mips_pkg::OP_SLTI: return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
         mips_pkg::OP_ANDI: return a & {16'h0, imm};
         mips_pkg::OP_ORI:  return a | {16'h0, imm};
         mips_pkg::OP_XORI: return a ^ {16'h0, imm};
         default:           return {imm, 16'h0};
      endcase
   endfunction

   task automatic emit(mips_pkg::word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   // store a register to its own slot and note what must end up there
   task automatic store_expect(logic [4:0] rt, int slot, mips_pkg::word_t value);
      emit(enc_i(mips_pkg::OP_SW, 5'd0, rt, 16'(slot * 4)));
      exp_slot.push_back(slot);
      exp_val.push_back(value);
   endtask

   task automatic load_const(logic [4:0] r, mips_pkg::word_t value);
      emit(enc_i(mips_pkg::OP_LUI, 5'd0, r, value[31:16]));
      emit(enc_i(mips_pkg::OP_ORI, r, r, value[15:0]));
   endtask

   // unused words hold an undecoded opcode, so a runaway pc halts
   task automatic clear_program();
      for (int i = 0; i < 1024; i++) begin
         imem[i] = {6'h3f, 16'h0, 10'(i)};
      end
      prog_len = 0;
      exp_slot.delete();
      exp_val.delete();
   endtask

   task automatic reset_core();
      @(posedge clk);
      rst_b <= 1'b0;
      apb   <= '0;
      repeat (3) @(posedge clk);
      rst_b <= 1'b1;
   endtask

   // one setup and one access cycle, response sampled mid access
   task automatic apb_access(logic wr, logic [3:0] addr, mips_pkg::word_t wdata,
                             output mips_pkg::word_t rdata, output logic err);
      @(posedge clk);
      apb <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      @(posedge clk);
      apb.penable <= 1'b1;
      @(negedge clk);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge clk);
      apb <= '0;
   endtask

   task automatic check_value(string name, mips_pkg::word_t expected, mips_pkg::word_t actual);
      checks++;
      assert (actual === expected) else begin
         $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected,
                  actual);
         value_errors++;
      end
   endtask

   task automatic wait_halted(int limit);
      int n;
      n = 0;
      while (!halted && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         $display("timeout: the core did not halt within %0d cycles", limit);
         $display("Verification failed");
         $finish;
      end
   endtask

   // frozen pc, exception record, slave errors and the data memory image
   task automatic check_halt(mips_pkg::word_t halt_pc, mips_pkg::word_t status);
      mips_pkg::word_t rdata;
      logic            err;
      repeat (4) begin
         @(negedge clk);
         check_value("inst_addr", {2'b00, halt_pc[31:2]}, {2'b00, inst_addr});
      end
      apb_access(1'b0, mips_pkg::CP0_EPC, 32'h0, rdata, err);
      check_value("EPC", halt_pc, rdata);
      apb_access(1'b0, mips_pkg::CP0_STATUS, 32'h0, rdata, err);
      check_value("STATUS", status, rdata);
      // offset 0xc has no register
      apb_access(1'b0, 4'hc, 32'h0, rdata, err);
      check_value("pslverr", 32'h1, {31'h0, err});
      check_value("prdata", 32'h0, rdata);
      apb_access(1'b1, mips_pkg::CP0_STATUS, 32'hffff_ffff, rdata, err);
      check_value("pslverr", 32'h1, {31'h0, err});
      check_value("prdata", 32'h0, rdata);
      foreach (exp_slot[i]) begin
         check_value($sformatf("dmem[%0d]", exp_slot[i]), exp_val[i], dmem_mem[exp_slot[i]]);
      end
   endtask

   initial begin
      mips_pkg::word_t a;
      mips_pkg::word_t b;
      mips_pkg::word_t rdata;
      mips_pkg::word_t syscall_pc;
      mips_pkg::word_t ri_pc;
      logic [15:0]     imm;
      logic [4:0]      sh;
      logic            err;
      int              slot;
      int              k;
      rst_b        = 1'b0;
      apb          = '0;
      checks       = 0;
      value_errors = 0;
      void'($urandom(32'h6f92));
      load_word = $urandom();

      // alu program, operands in $1 and $2, results through $3
      clear_program();
      a = $urandom();
      b = $urandom();
      if (a == b) begin
         b = ~a;
      end
      load_const(5'd1, a);
      load_const(5'd2, b);
      slot = 0;
      foreach (r_ops[i]) begin
         sh = 5'($urandom());
         emit(enc_r(r_ops[i], (i > 8) ? 5'd0 : 5'd1, 5'd2, 5'd3, sh));
         store_expect(5'd3, slot, r_result(r_ops[i], a, b, sh));
         slot++;
      end
      foreach (i_ops[i]) begin
         imm = 16'($urandom());
         emit(enc_i(i_ops[i], (i == 6) ? 5'd0 : 5'd1, 5'd3, imm));
         store_expect(5'd3, slot, i_result(i_ops[i], a, imm));
         slot++;
      end

      // load, adjust and store back
      imm = 16'($urandom());
      emit(enc_i(mips_pkg::OP_LW, 5'd0, 5'd4, 16'(LOAD_SLOT * 4)));
      emit(enc_i(mips_pkg::OP_ADDIU, 5'd4, 5'd4, imm));
      store_expect(5'd4, LOAD_SLOT + 1, load_word + {{16{imm[15]}}, imm});

      // skipped stores must leave the fill pattern
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd6, 16'h5a5a));
      emit(enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd1, 16'd1));
      store_expect(5'd6, 100, fill_word(100));
      emit(enc_i(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1));
      store_expect(5'd6, 101, 32'h5a5a);
      emit(enc_i(mips_pkg::OP_BNE, 5'd1, 5'd2, 16'd1));
      store_expect(5'd6, 102, fill_word(102));
      emit(enc_i(mips_pkg::OP_BNE, 5'd1, 5'd1, 16'd1));
      store_expect(5'd6, 103, 32'h5a5a);
      emit(enc_j(mips_pkg::OP_J, prog_len + 2));
      store_expect(5'd6, 104, fill_word(104));
      // jal into a jr that comes back to the link store
      k = prog_len;
      emit(enc_j(mips_pkg::OP_JAL, k + 4));
      store_expect(5'd31, 105, TEXT + 32'(k * 4) + 32'd4);
      emit(enc_j(mips_pkg::OP_J, k + 5));
      store_expect(5'd6, 106, fill_word(106));
      emit(enc_r(mips_pkg::FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
      syscall_pc = TEXT + 32'(prog_len * 4);
      emit(enc_r(mips_pkg::FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0));

      reset_core();
      // parked at text_start with run clear
      repeat (6) begin
         @(negedge clk);
         check_value("inst_addr", {2'b00, TEXT[31:2]}, {2'b00, inst_addr});
         check_value("halted", 32'h0, {31'h0, halted});
         check_value("dmem.we", 32'h0, {31'h0, dmem.we});
      end
      apb_access(1'b0, mips_pkg::CP0_STATUS, 32'h0, rdata, err);
      check_value("STATUS", 32'h0, rdata);
      apb_access(1'b1, mips_pkg::CP0_CTRL, 32'h1, rdata, err);
      wait_halted(2000);
      // halted in bit 0, cause 8 in bits 6:2
      check_halt(syscall_pc, 32'h21);

      // reserved opcode shaped like an immediate op into $7
      clear_program();
      emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd7, 16'h1234));
      store_expect(5'd7, 20, 32'h1234);
      ri_pc = TEXT + 32'(prog_len * 4);
      emit({6'h3f, 5'd0, 5'd7, 16'hbeef});
      store_expect(5'd7, 21, fill_word(21));
      reset_core();
      apb_access(1'b1, mips_pkg::CP0_CTRL, 32'h1, rdata, err);
      wait_halted(2000);
      // pc parked on the reserved word, its rt field puts $7 on the store data
      check_value("dmem.wdata", 32'h1234, dmem.wdata);
      check_halt(ri_pc, 32'h29);

      $display("checks: %0d, value errors: %0d, assertion failures: %0d", checks, value_errors,
               mips_core_top_i.mips_checker_i.fail_count);
      if (value_errors == 0 && mips_core_top_i.mips_checker_i.fail_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
